//--- udp_reassembly_config.svh
`ifndef UDP_REASSEMBLY_CONFIG_SVH
`define UDP_REASSEMBLY_CONFIG_SVH

//////////////////////////////////////////////////
// Reassembly sizing
//////////////////////////////////////////////////

// Number of fragment slots in the rotation
`define UDP_SLOT_COUNT 4

// Entries per slot FIFO, also the largest fragment in bytes
// Must stay a power of two
`define UDP_SLOT_DEPTH 4096

//////////////////////////////////////////////////
// Tag widths
//////////////////////////////////////////////////

// Packet id carried with every output byte
`define UDP_ID_WIDTH 16

`endif

//--- udp_reassembly_pkg.sv
`include "udp_reassembly_config.svh"

package udp_reassembly_pkg;

    //////////////////////////////////////////////////
    // FSM states
    //////////////////////////////////////////////////

    // Fragment slot life cycle
    typedef enum logic [1:0] {
        slot_idle,
        slot_capture,
        slot_drain
    } slot_state_t;

    // Drain arbiter
    typedef enum logic [1:0] {
        drain_wait,
        drain_pull,
        drain_finish
    } drain_state_t;

    //////////////////////////////////////////////////
    // Data words
    //////////////////////////////////////////////////

    // One slot FIFO entry
    typedef struct packed {
        logic       start;
        logic [7:0] data;
    } slot_byte_t;

    // Tagged byte leaving the subsystem
    typedef struct packed {
        logic [`UDP_ID_WIDTH-1:0] packet_id;
        logic                     start;
        logic [7:0]               data;
    } output_word_t;

endpackage

//--- synchronous_fifo.sv
`timescale 1ns/1ns

module synchronous_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DATA_DEPTH = 16
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  read_enable,
    input  logic                  write_enable,
    input  logic [DATA_WIDTH-1:0] write_data,
    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  read_data_valid,
    output logic                  full,
    output logic                  empty
);

    // DATA_DEPTH is expected to be a power of two
    localparam int ADDRESS_WIDTH = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;

    logic [DATA_WIDTH-1:0]  memory [0:DATA_DEPTH-1];
    logic [ADDRESS_WIDTH:0] write_pointer;
    logic [ADDRESS_WIDTH:0] read_pointer;
    logic                   write_accept;
    logic                   read_accept;

    //////////////////////////////////////////////////
    // Status flags
    //////////////////////////////////////////////////

    // Top pointer bit tells a full FIFO from an empty one
    assign empty = (write_pointer == read_pointer);
    assign full  = (write_pointer[ADDRESS_WIDTH] != read_pointer[ADDRESS_WIDTH]) &&
                   (write_pointer[ADDRESS_WIDTH-1:0] == read_pointer[ADDRESS_WIDTH-1:0]);

    // Overflow and underflow requests are dropped
    assign write_accept = write_enable && !full;
    assign read_accept  = read_enable && !empty;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (write_accept) begin
            memory[write_pointer[ADDRESS_WIDTH-1:0]] <= write_data;
        end
        if (read_accept) begin
            read_data <= memory[read_pointer[ADDRESS_WIDTH-1:0]];
        end
    end

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer   <= '0;
            read_pointer    <= '0;
            read_data_valid <= 1'b0;
        end else begin
            if (write_accept) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (read_accept) begin
                read_pointer <= read_pointer + 1'b1;
            end
            // Data shows up the cycle after the read
            read_data_valid <= read_accept;
        end
    end

endmodule

//--- udp_fragment_slot.sv
`timescale 1ns/1ns
`include "udp_reassembly_config.svh"

module udp_fragment_slot
    import udp_reassembly_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic [7:0]               data,
    input  logic                     data_enable,
    input  logic                     data_last,
    input  logic                     push_data_enable,
    input  logic [`UDP_ID_WIDTH-1:0] fragment_id,
    output logic                     ready,
    output logic                     data_ready,
    output slot_byte_t               push_data,
    output logic                     push_data_valid,
    output logic [`UDP_ID_WIDTH-1:0] current_packet_id
);

    slot_state_t              state;
    slot_state_t              next_state;
    slot_byte_t               buffer_data;
    slot_byte_t               next_buffer_data;
    logic                     buffer_data_valid;
    logic                     next_buffer_data_valid;
    logic [`UDP_ID_WIDTH-1:0] next_packet_id;
    logic                     fifo_empty;

    // Fragment storage, read side driven by the drain arbiter
    synchronous_fifo #(
        .DATA_WIDTH ($bits(slot_byte_t)),
        .DATA_DEPTH (`UDP_SLOT_DEPTH)
    ) i_fragment_fifo (
        .clock           (clock),
        .reset_n         (reset_n),
        .read_enable     (push_data_enable),
        .write_enable    (buffer_data_valid),
        .write_data      (buffer_data),
        .read_data       (push_data),
        .read_data_valid (push_data_valid),
        .full            (),
        .empty           (fifo_empty)
    );

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        next_state             = state;
        next_buffer_data       = buffer_data;
        next_buffer_data_valid = 1'b0;
        next_packet_id         = current_packet_id;

        case (state)
            slot_idle: begin
                // Id follows the input until a fragment starts
                next_packet_id = fragment_id;
                if (data_enable) begin
                    next_buffer_data       = '{start: 1'b1, data: data};
                    next_buffer_data_valid = 1'b1;
                    // Single byte fragment skips capture
                    next_state = data_last ? slot_drain : slot_capture;
                end
            end
            slot_capture: begin
                if (data_enable) begin
                    next_buffer_data       = '{start: 1'b0, data: data};
                    next_buffer_data_valid = 1'b1;
                end
                if (data_last) begin
                    next_state = slot_drain;
                end
            end
            slot_drain: begin
                // Last byte may still sit in the buffer register
                if (fifo_empty && !buffer_data_valid) begin
                    next_state = slot_idle;
                end
            end
            default: begin
                next_state = slot_idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state             <= slot_idle;
            ready             <= 1'b0;
            data_ready        <= 1'b0;
            buffer_data_valid <= 1'b0;
            current_packet_id <= '0;
        end else begin
            state             <= next_state;
            // Drops as soon as a first byte is taken
            ready             <= (state == slot_idle) && (next_state == slot_idle);
            data_ready        <= (state == slot_drain);
            buffer_data_valid <= next_buffer_data_valid;
            current_packet_id <= next_packet_id;
        end
    end

    always_ff @(posedge clock) begin
        buffer_data <= next_buffer_data;
    end

endmodule

//--- fragment_dispatcher.sv
`timescale 1ns/1ns
`include "udp_reassembly_config.svh"

module fragment_dispatcher (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       data_enable,
    input  logic                       data_last,
    input  logic [`UDP_SLOT_COUNT-1:0] slot_ready,
    output logic [`UDP_SLOT_COUNT-1:0] slot_data_enable,
    output logic [`UDP_SLOT_COUNT-1:0] slot_data_last,
    output logic                       input_busy
);

    localparam int SLOT_INDEX_WIDTH = (`UDP_SLOT_COUNT > 1) ? $clog2(`UDP_SLOT_COUNT) : 1;
    localparam logic [SLOT_INDEX_WIDTH-1:0] LAST_SLOT =
        SLOT_INDEX_WIDTH'(`UDP_SLOT_COUNT - 1);

    logic [SLOT_INDEX_WIDTH-1:0] write_pointer;
    logic                        in_fragment;
    logic                        accept;

    //////////////////////////////////////////////////
    // Flow control
    //////////////////////////////////////////////////

    // Busy whenever the next slot in line is still occupied
    assign input_busy = !slot_ready[write_pointer];

    // A fragment may only open on a free slot
    // Once open, every byte goes through until data_last
    assign accept = data_enable && (in_fragment || !input_busy);

    //////////////////////////////////////////////////
    // Strobe steering
    //////////////////////////////////////////////////

    always_comb begin
        slot_data_enable = '0;
        slot_data_last   = '0;

        // Only the slot owning the fragment sees the strobes
        slot_data_enable[write_pointer] = accept;
        slot_data_last[write_pointer]   = accept && data_last;
    end

    //////////////////////////////////////////////////
    // Write slot rotation
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            in_fragment   <= 1'b0;
        end else if (accept) begin
            if (data_last) begin
                in_fragment <= 1'b0;
                // Next fragment goes to the next slot in strict order
                if (write_pointer == LAST_SLOT) begin
                    write_pointer <= '0;
                end else begin
                    write_pointer <= write_pointer + 1'b1;
                end
            end else begin
                in_fragment <= 1'b1;
            end
        end
    end

endmodule

//--- slot_drain_arbiter.sv
`timescale 1ns/1ns
`include "udp_reassembly_config.svh"

module slot_drain_arbiter
    import udp_reassembly_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic [`UDP_SLOT_COUNT-1:0] slot_data_ready,
    input  slot_byte_t                 slot_push_data [0:`UDP_SLOT_COUNT-1],
    input  logic [`UDP_SLOT_COUNT-1:0] slot_push_valid,
    input  logic [`UDP_ID_WIDTH-1:0]   slot_packet_id [0:`UDP_SLOT_COUNT-1],
    input  logic                       out_hold,
    output logic [`UDP_SLOT_COUNT-1:0] push_data_enable,
    output output_word_t               out_word,
    output logic                       out_valid
);

    localparam int SLOT_INDEX_WIDTH = (`UDP_SLOT_COUNT > 1) ? $clog2(`UDP_SLOT_COUNT) : 1;
    localparam logic [SLOT_INDEX_WIDTH-1:0] LAST_SLOT =
        SLOT_INDEX_WIDTH'(`UDP_SLOT_COUNT - 1);

    drain_state_t                state;
    drain_state_t                next_state;
    logic [SLOT_INDEX_WIDTH-1:0] drain_pointer;
    logic [`UDP_ID_WIDTH-1:0]    granted_packet_id;

    //////////////////////////////////////////////////
    // Drain FSM
    //////////////////////////////////////////////////

    always_comb begin
        next_state       = state;
        push_data_enable = '0;

        case (state)
            drain_wait: begin
                if (slot_data_ready[drain_pointer]) begin
                    next_state = drain_pull;
                end
            end
            drain_pull: begin
                // One read per cycle unless the sink holds
                if (slot_data_ready[drain_pointer]) begin
                    push_data_enable[drain_pointer] = !out_hold;
                end else begin
                    next_state = drain_finish;
                end
            end
            drain_finish: begin
                next_state = drain_wait;
            end
            default: begin
                next_state = drain_wait;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= drain_wait;
            drain_pointer <= '0;
        end else begin
            state <= next_state;
            // Move on once the last read has landed
            if (state == drain_finish) begin
                drain_pointer <= (drain_pointer == LAST_SLOT) ? '0 : drain_pointer + 1'b1;
            end
        end
    end

    // Id is captured at grant and held for the whole fragment
    always_ff @(posedge clock) begin
        if ((state == drain_wait) && slot_data_ready[drain_pointer]) begin
            granted_packet_id <= slot_packet_id[drain_pointer];
        end
    end

    //////////////////////////////////////////////////
    // Output word
    //////////////////////////////////////////////////

    // Slot FIFO output is already registered
    assign out_valid = slot_push_valid[drain_pointer];
    assign out_word  = '{packet_id: granted_packet_id,
                         start:     slot_push_data[drain_pointer].start,
                         data:      slot_push_data[drain_pointer].data};

endmodule

//--- udp_reassembly_top.sv
`timescale 1ns/1ns
`include "udp_reassembly_config.svh"

module udp_reassembly_top
    import udp_reassembly_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic [7:0]               data,
    input  logic                     data_enable,
    input  logic                     data_last,
    input  logic [`UDP_ID_WIDTH-1:0] fragment_id,
    input  logic                     out_hold,
    output logic                     input_busy,
    output output_word_t             out_word,
    output logic                     out_valid
);

    logic [`UDP_SLOT_COUNT-1:0] slot_ready;
    logic [`UDP_SLOT_COUNT-1:0] slot_data_enable;
    logic [`UDP_SLOT_COUNT-1:0] slot_data_last;
    logic [`UDP_SLOT_COUNT-1:0] slot_data_ready;
    logic [`UDP_SLOT_COUNT-1:0] push_data_enable;
    logic [`UDP_SLOT_COUNT-1:0] slot_push_valid;
    slot_byte_t                 slot_push_data [0:`UDP_SLOT_COUNT-1];
    logic [`UDP_ID_WIDTH-1:0]   slot_packet_id [0:`UDP_SLOT_COUNT-1];

    // Input side
    fragment_dispatcher i_dispatcher (
        .clock            (clock),
        .reset_n          (reset_n),
        .data_enable      (data_enable),
        .data_last        (data_last),
        .slot_ready       (slot_ready),
        .slot_data_enable (slot_data_enable),
        .slot_data_last   (slot_data_last),
        .input_busy       (input_busy)
    );

    //////////////////////////////////////////////////
    // Slot array
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `UDP_SLOT_COUNT; i++) begin : g_slot
        udp_fragment_slot i_slot (
            .clock             (clock),
            .reset_n           (reset_n),
            .data              (data),
            .data_enable       (slot_data_enable[i]),
            .data_last         (slot_data_last[i]),
            .push_data_enable  (push_data_enable[i]),
            .fragment_id       (fragment_id),
            .ready             (slot_ready[i]),
            .data_ready        (slot_data_ready[i]),
            .push_data         (slot_push_data[i]),
            .push_data_valid   (slot_push_valid[i]),
            .current_packet_id (slot_packet_id[i])
        );
    end

    // Output side
    slot_drain_arbiter i_arbiter (
        .clock            (clock),
        .reset_n          (reset_n),
        .slot_data_ready  (slot_data_ready),
        .slot_push_data   (slot_push_data),
        .slot_push_valid  (slot_push_valid),
        .slot_packet_id   (slot_packet_id),
        .out_hold         (out_hold),
        .push_data_enable (push_data_enable),
        .out_word         (out_word),
        .out_valid        (out_valid)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset_n
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Released on a falling edge, away from the active edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

//--- udp_reassembly_tb.sv
`timescale 1ns/1ns
`include "udp_reassembly_config.svh"

module udp_reassembly_tb
    import udp_reassembly_pkg::*;
();

    localparam int         ROW_LIMIT      = 24;
    localparam int         TIMEOUT_MARGIN = 1000;
    localparam int         BUSY_CYCLES    = 20;
    localparam int         SETTLE_CYCLES  = 20;
    localparam logic [1:0] HOLD_LOW       = 2'd0;
    localparam logic [1:0] HOLD_RANDOM    = 2'd1;
    localparam logic [1:0] HOLD_HIGH      = 2'd2;

    typedef struct {
        string                    name;
        logic [`UDP_ID_WIDTH-1:0] packet_id;
        int                       length;
        logic [1:0]               hold_mode;
        logic                     random_gap;
        logic                     wait_drain;
        logic                     check_busy;
    } fragment_row_t;

    logic                     clock;
    logic                     reset_n;
    logic [7:0]               data;
    logic                     data_enable;
    logic                     data_last;
    logic [`UDP_ID_WIDTH-1:0] fragment_id;
    logic                     out_hold;
    logic                     input_busy;
    output_word_t             out_word;
    logic                     out_valid;

    fragment_row_t table_rows [0:ROW_LIMIT-1];
    int            row_count      = 0;
    output_word_t  expected_words [$];
    string         expected_names [$];
    int            cycle_count    = 0;
    int            cycle_limit    = 0;
    logic [31:0]   data_lfsr      = 32'h1643;
    logic [31:0]   hold_lfsr      = 32'h1643;
    logic [1:0]    hold_mode      = HOLD_LOW;
    logic          hold_at_edge   = 1'b0;

    tb_clock_gen i_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    udp_reassembly_top i_dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .data        (data),
        .data_enable (data_enable),
        .data_last   (data_last),
        .fragment_id (fragment_id),
        .out_hold    (out_hold),
        .input_busy  (input_busy),
        .out_word    (out_word),
        .out_valid   (out_valid)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic draw_bits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[6:0], data_lfsr[0]};
            data_lfsr = lfsr_step(data_lfsr);
        end
    endtask

    task automatic report_failure();
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first failing check");
    endtask

    task automatic check_output_word(input string name, input output_word_t expected,
                                     input output_word_t actual);
        if (actual !== expected) begin
            $display("** Error [%s] expected id %h start %b data %h, actual id %h start %b data %h",
                     name, expected.packet_id, expected.start, expected.data,
                     actual.packet_id, actual.start, actual.data);
            report_failure();
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error [%s] expected %b actual %b", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic add_row(input string name, input logic [`UDP_ID_WIDTH-1:0] packet_id,
                           input int length, input logic [1:0] hold, input logic gap,
                           input logic drain, input logic busy);
        table_rows[row_count] = '{name, packet_id, length, hold, gap, drain, busy};
        row_count++;
    endtask

    task automatic build_table();
        int lengths [0:5];
        lengths = '{5, 17, 1, 64, 3, 9};
        add_row("single_len1", 16'h0a01, 1, HOLD_LOW, 1'b1, 1'b0, 1'b0);
        add_row("single_len2", 16'h0a02, 2, HOLD_LOW, 1'b1, 1'b0, 1'b0);
        add_row("single_len300", 16'h0a03, 300, HOLD_LOW, 1'b1, 1'b0, 1'b0);
        // More fragments than slots with no gaps
        for (int i = 0; i < 6; i++) begin
            add_row($sformatf("back_to_back_%0d", i), 16'h1b00 + 16'(i), lengths[i],
                    HOLD_LOW, 1'b0, 1'b0, 1'b0);
        end
        lengths = '{40, 1, 100, 7, 25, 0};
        for (int i = 0; i < 5; i++) begin
            add_row($sformatf("hold_random_%0d", i), 16'h2c00 + 16'(i), lengths[i],
                    HOLD_RANDOM, 1'b1, 1'b0, 1'b0);
        end
        // One fragment per slot while the sink holds
        add_row("all_slots_busy_0", 16'h3d00, 12, HOLD_HIGH, 1'b0, 1'b1, 1'b0);
        add_row("all_slots_busy_1", 16'h3d01, 1, HOLD_HIGH, 1'b0, 1'b0, 1'b0);
        add_row("all_slots_busy_2", 16'h3d02, 30, HOLD_HIGH, 1'b0, 1'b0, 1'b0);
        add_row("all_slots_busy_3", 16'h3d03, 6, HOLD_HIGH, 1'b0, 1'b0, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic drive_fragment(input fragment_row_t row);
        logic [7:0]   value;
        output_word_t word;
        if (row.random_gap) begin
            draw_bits(2, value);
            repeat (value[1:0]) @(negedge clock);
        end
        // A fragment may only start on a free slot
        while (input_busy) begin
            @(negedge clock);
        end
        for (int i = 0; i < row.length; i++) begin
            draw_bits(8, value);
            data        = value;
            data_enable = 1'b1;
            data_last   = (i == row.length - 1);
            // Id only counts with the first byte
            fragment_id = (i == 0) ? row.packet_id : ~row.packet_id;
            word.packet_id = row.packet_id;
            word.start     = (i == 0);
            word.data      = value;
            expected_words.push_back(word);
            expected_names.push_back(row.name);
            @(negedge clock);
        end
        data_enable = 1'b0;
        data_last   = 1'b0;
        fragment_id = ~row.packet_id;
    endtask

    task automatic run_row(input fragment_row_t row);
        if (row.wait_drain) begin
            while (expected_words.size() != 0) begin
                @(negedge clock);
            end
        end
        hold_mode = row.hold_mode;
        drive_fragment(row);
        if (row.check_busy) begin
            check_level(row.name, 1'b1, input_busy);
            repeat (BUSY_CYCLES) begin
                @(negedge clock);
                check_level(row.name, 1'b1, input_busy);
            end
            // Draining resumes and frees the oldest slot
            hold_mode = HOLD_LOW;
            while (input_busy) begin
                @(negedge clock);
            end
        end
    endtask

    initial begin
        int total_bytes;
        data        = '0;
        data_enable = 1'b0;
        data_last   = 1'b0;
        fragment_id = '0;
        build_table();
        total_bytes = 0;
        for (int i = 0; i < row_count; i++) begin
            total_bytes += table_rows[i].length;
        end
        cycle_limit = total_bytes * 4 + TIMEOUT_MARGIN;

        @(posedge clock);
        @(negedge clock);
        check_level("reset_out_valid", 1'b0, out_valid);
        wait (reset_n == 1'b1);
        // Slots report ready on the first clock
        @(posedge clock);
        @(negedge clock);
        check_level("after_reset_out_valid", 1'b0, out_valid);
        check_level("after_reset_input_busy", 1'b0, input_busy);

        for (int i = 0; i < row_count; i++) begin
            run_row(table_rows[i]);
        end
        hold_mode = HOLD_LOW;
        while (expected_words.size() != 0) begin
            @(negedge clock);
        end
        repeat (SETTLE_CYCLES) @(negedge clock);

        $display("** PASS **");
        $finish;
    end

    //////////////////////////////////////////////////
    // Sink hold, monitor and timeout
    //////////////////////////////////////////////////

    initial begin
        out_hold = 1'b0;
        forever begin
            @(negedge clock);
            case (hold_mode)
                HOLD_RANDOM: begin
                    out_hold  = hold_lfsr[0];
                    hold_lfsr = lfsr_step(hold_lfsr);
                end
                HOLD_HIGH: out_hold = 1'b1;
                default:   out_hold = 1'b0;
            endcase
        end
    end

    // Hold level seen by the arbiter when it issued the read
    always @(posedge clock) begin
        hold_at_edge <= out_hold;
    end

    initial begin
        output_word_t expected;
        string        name;
        forever begin
            @(negedge clock);
            if (reset_n && out_valid) begin
                if (expected_words.size() == 0) begin
                    $display("Output word %h appeared with no word left to expect", out_word);
                    report_failure();
                end else begin
                    expected = expected_words.pop_front();
                    name     = expected_names.pop_front();
                    check_output_word(name, expected, out_word);
                    check_level({name, "_read_under_hold"}, 1'b0, hold_at_edge);
                end
            end
        end
    end

    always @(posedge clock) begin
        if (reset_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout after %0d cycles with %0d words still expected",
                         cycle_count, expected_words.size());
                report_failure();
            end
        end
    end

endmodule

//--- udp_reassembly.f
+incdir+.
udp_reassembly_pkg.sv
synchronous_fifo.sv
udp_fragment_slot.sv
fragment_dispatcher.sv
slot_drain_arbiter.sv
udp_reassembly_top.sv
tb_clock_gen.sv
udp_reassembly_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing
TOP       := udp_reassembly_tb
FILE_LIST := udp_reassembly.f

BUILD_DIR  := obj_dir
SIM_BINARY := $(BUILD_DIR)/V$(TOP)
SOURCES    := $(filter-out +%,$(shell cat $(FILE_LIST))) $(wildcard *.svh)

.PHONY: all run clean

all: $(SIM_BINARY)

# Rebuilt only when a source, header or the file list changes
$(SIM_BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Exit status of the simulator is the test result
run: $(SIM_BINARY)
	./$(SIM_BINARY)

clean:
	rm -rf $(BUILD_DIR)
